// ==== hw/bru_macros.svh ====
// widths, reset pc and trap vector shared by the branch slice; include before any module using them.
`ifndef BRU_MACROS_SVH
`define BRU_MACROS_SVH

// operand width of rs1, rs2 and the immediate.
`define WORD_WD 32

// program counter width.
`define PC_WD 32

// pc loaded on reset.
`define RESET_PC 32'h8000_0000

// fixed ecall target, no writable mtvec.
`define TRAP_VEC 32'h8000_0100

`endif

// ==== hw/rv_inst_pkg.sv ====
// rv32i opcode values and instruction format views; referenced by scoped name from the decoder.
package rv_inst_pkg;

  // only the control-transfer opcodes are named.
  typedef enum logic [6:0] {
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef struct packed {
    logic       imm12;    // inst[31].
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;    // inst[7].
    logic [6:0] opcode;
  } b_inst_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_inst_t;

  typedef struct packed {
    logic       imm20;    // sign bit.
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_inst_t;

  // one word, read in the format its opcode selects.
  typedef union packed {
    b_inst_t b;
    i_inst_t i;
    j_inst_t j;
  } inst_u;

endpackage

// ==== hw/br_pkg.sv ====
// branch function and exception kind encodings shared by decoder, branch unit and pc control.
package br_pkg;

  // encoding follows the original branch unit lookup keys.
  typedef enum logic [2:0] {
    BR_JAL  = 3'd0,
    BR_JALR = 3'd1,
    BR_BEQ  = 3'd2,
    BR_BNE  = 3'd3,
    BR_BLT  = 3'd4,
    BR_BGE  = 3'd5,
    BR_BLTU = 3'd6,
    BR_BGEU = 3'd7
  } brfunc_e;

  typedef enum logic [1:0] {
    EP_NONE  = 2'd0,
    EP_ECALL = 2'd1,
    EP_MRET  = 2'd2
  } ep_kind_e;

endpackage

// ==== hw/br_bus_if.sv ====
// decoded branch request bus; the decoder drives it through dec and the branch unit reads it.
`timescale 1ns/1ns
`include "bru_macros.svh"

interface br_bus_if;

  logic                bren;     // branch, jal or jalr.
  br_pkg::brfunc_e     brfunc;
  logic [`WORD_WD-1:0] imm;      // already sign extended.
  br_pkg::ep_kind_e    ep_kind;

  modport dec (
    output bren,
    output brfunc,
    output imm,
    output ep_kind
  );

  modport bru (
    input  bren,
    input  brfunc,
    input  imm,
    input  ep_kind
  );

endinterface

// ==== hw/br_decode.sv ====
// combinational decoder from one rv32i word to the branch request and exception kind.
`timescale 1ns/1ns
`include "bru_macros.svh"

module br_decode (
  input  rv_inst_pkg::inst_u i_inst,
  output br_pkg::ep_kind_e   o_ep_kind,
  br_bus_if.dec              br
);

  logic [`WORD_WD-1:0] b_imm;
  logic [`WORD_WD-1:0] i_imm;
  logic [`WORD_WD-1:0] j_imm;
  logic                sys_zero;
  br_pkg::ep_kind_e    ep_kind;

  // immediates rebuilt from the scattered fields.
  assign b_imm = {{(`WORD_WD-13){i_inst.b.imm12}}, i_inst.b.imm12, i_inst.b.imm11,
                  i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
  assign i_imm = {{(`WORD_WD-12){i_inst.i.imm12[11]}}, i_inst.i.imm12};
  assign j_imm = {{(`WORD_WD-21){i_inst.j.imm20}}, i_inst.j.imm20, i_inst.j.imm19_12,
                  i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};

  // ecall and mret have rs1, funct3 and rd all zero.
  assign sys_zero = (i_inst.i.rs1 == 5'd0) && (i_inst.i.funct3 == 3'd0) &&
                    (i_inst.i.rd == 5'd0);

  always_comb begin
    br.bren   = 1'b0;
    br.brfunc = br_pkg::BR_JAL;
    br.imm    = '0;
    ep_kind   = br_pkg::EP_NONE;
    case (i_inst.b.opcode)
      rv_inst_pkg::OP_BRANCH: begin
        br.bren = 1'b1;
        br.imm  = b_imm;
        case (i_inst.b.funct3)
          3'b000:  br.brfunc = br_pkg::BR_BEQ;
          3'b001:  br.brfunc = br_pkg::BR_BNE;
          3'b100:  br.brfunc = br_pkg::BR_BLT;
          3'b101:  br.brfunc = br_pkg::BR_BGE;
          3'b110:  br.brfunc = br_pkg::BR_BLTU;
          3'b111:  br.brfunc = br_pkg::BR_BGEU;
          default: br.bren   = 1'b0;   // 010 and 011 are reserved.
        endcase
      end
      rv_inst_pkg::OP_JAL: begin
        br.bren   = 1'b1;
        br.brfunc = br_pkg::BR_JAL;
        br.imm    = j_imm;
      end
      rv_inst_pkg::OP_JALR: begin
        if (i_inst.i.funct3 == 3'd0) begin
          br.bren   = 1'b1;
          br.brfunc = br_pkg::BR_JALR;
          br.imm    = i_imm;
        end
      end
      rv_inst_pkg::OP_SYSTEM: begin
        if (sys_zero && (i_inst.i.imm12 == 12'h000)) begin
          ep_kind = br_pkg::EP_ECALL;
        end else if (sys_zero && (i_inst.i.imm12 == 12'h302)) begin
          ep_kind = br_pkg::EP_MRET;
        end
      end
      default: ;   // anything else falls through as pc + 4.
    endcase
  end

  assign br.ep_kind = ep_kind;
  assign o_ep_kind  = ep_kind;

endmodule

// ==== hw/bru.sv ====
// combinational branch unit; compares operands and gives taken and target for the current pc.
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru (
  br_bus_if.bru              br,
  input  logic [`WORD_WD-1:0] i_rs1data,
  input  logic [`WORD_WD-1:0] i_rs2data,
  input  logic [`PC_WD-1:0]   i_pc,
  input  logic                i_ep_sel,   // exception redirect.
  input  logic [`PC_WD-1:0]   i_epnpc,
  output logic                o_br_taken,
  output logic [`PC_WD-1:0]   o_br_target
);

  logic [`WORD_WD:0]   sub_full;
  logic [`WORD_WD-1:0] sub_result;
  logic                carry;
  logic                overflow;
  logic                zero;
  logic                signed_less;
  logic                unsigned_less;
  logic                br_req;
  logic                cond;
  logic                pc_a_src;   // offset is imm, else 4.
  logic                pc_b_src;   // base is rs1, else pc.
  logic [`PC_WD-1:0]   sum;

  // rs1 - rs2 as rs1 + ~rs2 + 1, carry kept.
  assign sub_full   = {1'b0, i_rs1data} + {1'b0, ~i_rs2data} + {{`WORD_WD{1'b0}}, 1'b1};
  assign sub_result = sub_full[`WORD_WD-1:0];
  assign carry      = sub_full[`WORD_WD];

  assign zero          = ~(|sub_result);
  assign overflow      = (i_rs1data[`WORD_WD-1] ^ i_rs2data[`WORD_WD-1]) &
                         (i_rs1data[`WORD_WD-1] ^ sub_result[`WORD_WD-1]);
  assign signed_less   = sub_result[`WORD_WD-1] ^ overflow;
  assign unsigned_less = ~carry;   // no carry out means a borrow.

  // exception words never take the compare path.
  assign br_req = br.bren & (br.ep_kind == br_pkg::EP_NONE);

  always_comb begin
    case (br.brfunc)
      br_pkg::BR_JAL,
      br_pkg::BR_JALR: cond = 1'b1;
      br_pkg::BR_BEQ:  cond = zero;
      br_pkg::BR_BNE:  cond = ~zero;
      br_pkg::BR_BLT:  cond = signed_less;
      br_pkg::BR_BGE:  cond = ~signed_less;
      br_pkg::BR_BLTU: cond = unsigned_less;
      br_pkg::BR_BGEU: cond = ~unsigned_less;
      default:         cond = 1'b0;
    endcase
  end

  assign pc_a_src = br_req & cond;
  assign pc_b_src = br_req & (br.brfunc == br_pkg::BR_JALR);

  assign sum = (pc_b_src ? i_rs1data : i_pc) + (pc_a_src ? br.imm : `PC_WD'(4));

  assign o_br_taken  = pc_a_src | i_ep_sel;
  assign o_br_target = i_ep_sel ? i_epnpc
                     : {sum[`PC_WD-1:1], sum[0] & ~pc_b_src};   // jalr drops bit 0.

endmodule

// ==== hw/pc_ctrl.sv ====
// pc and mepc owner; maps the exception kind to a redirect and commits the next pc each valid cycle.
`timescale 1ns/1ns
`include "bru_macros.svh"

module pc_ctrl (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_valid,
  input  br_pkg::ep_kind_e  i_ep_kind,
  input  logic              i_taken,
  input  logic [`PC_WD-1:0] i_target,
  output logic              o_ep_sel,
  output logic [`PC_WD-1:0] o_epnpc,
  output logic [`PC_WD-1:0] o_pc,
  output logic              o_br_taken
);

  logic [`PC_WD-1:0] pc_q;
  logic [`PC_WD-1:0] mepc_q;
  logic [`PC_WD-1:0] pc_d;
  logic              is_ecall;
  logic              is_mret;

  assign is_ecall = (i_ep_kind == br_pkg::EP_ECALL);
  assign is_mret  = (i_ep_kind == br_pkg::EP_MRET);

  // ecall goes to the trap vector, mret back to mepc.
  assign o_ep_sel = is_ecall | is_mret;
  assign o_epnpc  = is_mret ? mepc_q : `TRAP_VEC;

  assign o_br_taken = i_valid & i_taken;
  assign pc_d       = o_br_taken ? i_target : pc_q + `PC_WD'(4);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q   <= `RESET_PC;
      mepc_q <= '0;
    end else if (i_valid) begin
      pc_q <= pc_d;
      if (is_ecall) begin
        mepc_q <= pc_q;   // pc of the ecall itself.
      end
    end
  end

  assign o_pc = pc_q;

endmodule

// ==== hw/bru_top.sv ====
// top of the control-transfer slice; joins decoder, branch unit and pc control to plain ports.
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_top (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_valid,    // instruction at o_pc executes now.
  input  logic [31:0]         i_inst,
  input  logic [`WORD_WD-1:0] i_rs1data,
  input  logic [`WORD_WD-1:0] i_rs2data,
  output logic [`PC_WD-1:0]   o_pc,
  output logic                o_br_taken,
  output logic [`PC_WD-1:0]   o_br_target
);

  br_pkg::ep_kind_e  ep_kind;
  logic              ep_sel;
  logic [`PC_WD-1:0] epnpc;
  logic              bru_taken;   // before the valid gate.

  br_bus_if br ();

  br_decode u_decode (
    .i_inst    (i_inst),
    .o_ep_kind (ep_kind),
    .br        (br.dec)
  );

  bru u_bru (
    .br          (br.bru),
    .i_rs1data   (i_rs1data),
    .i_rs2data   (i_rs2data),
    .i_pc        (o_pc),
    .i_ep_sel    (ep_sel),
    .i_epnpc     (epnpc),
    .o_br_taken  (bru_taken),
    .o_br_target (o_br_target)
  );

  pc_ctrl u_pc_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_ep_kind  (ep_kind),
    .i_taken    (bru_taken),
    .i_target   (o_br_target),
    .o_ep_sel   (ep_sel),
    .o_epnpc    (epnpc),
    .o_pc       (o_pc),
    .o_br_taken (o_br_taken)
  );

endmodule

// ==== dv/bru_props.sv ====
// concurrent checks on pc sequencing; bound into pc_ctrl from the testbench.
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_props (
  input logic              i_clk,
  input logic              i_rst_n,
  input logic              i_valid,
  input logic              i_br_taken,   // already gated by valid.
  input logic [`PC_WD-1:0] i_target,
  input logic [`PC_WD-1:0] i_pc
);

  // a single reset edge loads the reset pc.
  pc_after_reset: assert property (@(posedge i_clk) !i_rst_n |=> i_pc == `RESET_PC)
    else $error("pc is not the reset value after reset");

  taken_goes_to_target: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_valid && i_br_taken) |=> i_pc == $past(i_target))
    else $error("pc did not follow the taken target");

  not_taken_steps_four: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_valid && !i_br_taken) |=> i_pc == $past(i_pc) + `PC_WD'(4))
    else $error("pc did not advance by 4 on a not-taken cycle");

  // an idle cycle leaves the pc where it was.
  pc_holds_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_valid |=> i_pc == $past(i_pc))
    else $error("pc moved while valid is low");

endmodule

// ==== dv/bru_tb.sv ====
// directed testbench for bru_top; runs branch, jump, trap and idle cases and checks pc flow.
`timescale 1ns/1ns
`include "bru_macros.svh"

module bru_tb;

  logic                clk;
  logic                rst_n;
  logic                valid;
  logic [31:0]         inst;
  logic [`WORD_WD-1:0] rs1;
  logic [`WORD_WD-1:0] rs2;
  logic [`PC_WD-1:0]   pc;
  logic                taken;
  logic [`PC_WD-1:0]   target;

  logic [15:0]         lfsr_q;
  logic [`PC_WD-1:0]   pc_model;     // expected pc from the branch rules.
  logic [`PC_WD-1:0]   mepc_model;   // pc of the last ecall.
  logic                reset_ok;
  int                  errors;
  int                  checks;
  int                  tests;

  bru_top i_dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_valid     (valid),
    .i_inst      (inst),
    .i_rs1data   (rs1),
    .i_rs2data   (rs2),
    .o_pc        (pc),
    .o_br_taken  (taken),
    .o_br_target (target)
  );

  bind pc_ctrl bru_props u_props (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .i_br_taken (o_br_taken),
    .i_target   (i_target),
    .i_pc       (o_pc)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[30:0], lfsr_q[0]};   // one step per bit.
    end
  endtask

  function automatic logic [2:0] funct3_of(input br_pkg::brfunc_e f);
    case (f)
      br_pkg::BR_BEQ:  return 3'b000;
      br_pkg::BR_BNE:  return 3'b001;
      br_pkg::BR_BLT:  return 3'b100;
      br_pkg::BR_BGE:  return 3'b101;
      br_pkg::BR_BLTU: return 3'b110;
      br_pkg::BR_BGEU: return 3'b111;
      default:         return 3'b010;
    endcase
  endfunction

  function automatic logic [31:0] b_word(input logic [2:0] f3, input logic [12:0] off);
    rv_inst_pkg::inst_u u;
    u.b.imm12   = off[12];
    u.b.imm10_5 = off[10:5];
    u.b.rs2     = 5'd2;
    u.b.rs1     = 5'd1;
    u.b.funct3  = f3;
    u.b.imm4_1  = off[4:1];
    u.b.imm11   = off[11];
    u.b.opcode  = rv_inst_pkg::OP_BRANCH;
    return u;
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] reg_f, input logic [11:0] imm);
    rv_inst_pkg::inst_u u;
    u.i.imm12  = imm;
    u.i.rs1    = reg_f;
    u.i.funct3 = f3;
    u.i.rd     = reg_f;
    u.i.opcode = op;
    return u;
  endfunction

  function automatic logic [31:0] j_word(input logic [20:0] off);
    rv_inst_pkg::inst_u u;
    u.j.imm20    = off[20];
    u.j.imm10_1  = off[10:1];
    u.j.imm11    = off[11];
    u.j.imm19_12 = off[19:12];
    u.j.rd       = 5'd1;
    u.j.opcode   = rv_inst_pkg::OP_JAL;
    return u;
  endfunction

  // expected branch condition straight from the isa definition.
  function automatic logic cond_holds(input br_pkg::brfunc_e f, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f)
      br_pkg::BR_BEQ:  return a == b;
      br_pkg::BR_BNE:  return a != b;
      br_pkg::BR_BLT:  return $signed(a) < $signed(b);
      br_pkg::BR_BGE:  return $signed(a) >= $signed(b);
      br_pkg::BR_BLTU: return a < b;
      br_pkg::BR_BGEU: return a >= b;
      default:         return 1'b1;   // jal and jalr.
    endcase
  endfunction

  task automatic check_word(input string what, input logic [`PC_WD-1:0] got,
                            input logic [`PC_WD-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  task automatic wait_reset_done(output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < 20) begin
      @(negedge clk);
      if (rst_n) begin
        ok = 1'b1;
      end
      cycles++;
    end
    if (!ok) begin
      $display("timeout: reset was never released");
    end
  endtask

  // one valid cycle; result checked mid cycle, committed pc one clock later.
  task automatic exec(input logic [31:0] w, input logic [`WORD_WD-1:0] a,
                      input logic [`WORD_WD-1:0] b, input logic exp_tk,
                      input logic [`PC_WD-1:0] exp_tgt);
    logic [`PC_WD-1:0] pc_exp;
    @(posedge clk);
    inst  <= w;
    rs1   <= a;
    rs2   <= b;
    valid <= 1'b1;
    @(negedge clk);
    check_bit("o_br_taken", taken, exp_tk);
    check_word("o_br_target", target, exp_tgt);
    pc_exp = exp_tk ? exp_tgt : pc_model + `PC_WD'(4);
    @(posedge clk);
    valid <= 1'b0;
    @(negedge clk);
    check_word("o_pc after commit", pc, pc_exp);
    pc_model = pc_exp;
  endtask

  task automatic idle_cycle(input logic [31:0] w);
    @(posedge clk);
    inst <= w;
    @(negedge clk);
    check_bit("o_br_taken while idle", taken, 1'b0);
    @(posedge clk);
    @(negedge clk);
    check_word("o_pc while idle", pc, pc_model);
  endtask

  task automatic test_reset();
    int start;
    start = errors;
    check_word("o_pc after reset", pc, `RESET_PC);
    check_bit("o_br_taken after reset", taken, 1'b0);
    end_test("reset", start);
  endtask

  task automatic test_cond();
    br_pkg::brfunc_e     funcs [6];
    logic [`WORD_WD-1:0] a;
    logic [`WORD_WD-1:0] b;
    logic [`WORD_WD-1:0] r;
    logic [`WORD_WD-1:0] imm;
    logic                tk;
    int                  start;
    start = errors;
    funcs = '{br_pkg::BR_BEQ, br_pkg::BR_BNE, br_pkg::BR_BLT,
              br_pkg::BR_BGE, br_pkg::BR_BLTU, br_pkg::BR_BGEU};
    foreach (funcs[n]) begin
      for (int k = 0; k < 9; k++) begin
        rand_word(a);
        rand_word(b);
        rand_word(r);
        case (k)
          3: b = a;
          4: begin
            a = '0;
            b = '0;
          end
          5: a = '0;
          6: begin
            a = 32'h8000_0000;   // most negative against most positive.
            b = 32'h7fff_ffff;
          end
          7: begin
            a = 32'h7fff_ffff;
            b = 32'h8000_0000;
          end
          8: begin
            a = 32'hffff_ffff;
            b = 32'h0000_0001;
          end
          default: ;
        endcase
        imm = {{19{r[12]}}, r[12:1], 1'b0};
        tk  = cond_holds(funcs[n], a, b);
        exec(b_word(funct3_of(funcs[n]), imm[12:0]), a, b, tk,
             tk ? pc_model + imm : pc_model + `PC_WD'(4));
      end
    end
    end_test("conditional branches", start);
  endtask

  task automatic test_jump();
    logic [`WORD_WD-1:0] a;
    logic [`WORD_WD-1:0] r;
    logic [`WORD_WD-1:0] imm;
    int                  start;
    start = errors;
    for (int k = 0; k < 4; k++) begin
      rand_word(r);
      imm = {{11{r[20]}}, r[20:1], 1'b0};
      exec(j_word(imm[20:0]), r, r, 1'b1, pc_model + imm);
    end
    for (int k = 0; k < 4; k++) begin
      rand_word(a);
      rand_word(r);
      a[0] = k[0];   // both parities of rs1.
      imm  = {{20{r[11]}}, r[11:0]};
      exec(i_word(rv_inst_pkg::OP_JALR, 3'b000, 5'd1, imm[11:0]), a, r, 1'b1,
           (a + imm) & ~32'd1);
    end
    end_test("jal and jalr", start);
  endtask

  task automatic test_trap();
    logic [`WORD_WD-1:0] a;
    int                  start;
    start = errors;
    rand_word(a);
    mepc_model = pc_model;
    exec(i_word(rv_inst_pkg::OP_SYSTEM, 3'b000, 5'd0, 12'h000), a, a, 1'b1, `TRAP_VEC);
    exec(i_word(7'b001_0011, 3'b000, 5'd1, 12'h001), a, a, 1'b0, pc_model + `PC_WD'(4));
    exec(i_word(rv_inst_pkg::OP_SYSTEM, 3'b000, 5'd0, 12'h302), a, a, 1'b1, mepc_model);
    end_test("ecall and mret", start);
  endtask

  task automatic test_plain();
    logic [`WORD_WD-1:0] a;
    logic [`WORD_WD-1:0] r;
    int                  start;
    start = errors;
    rand_word(a);
    rand_word(r);
    exec(i_word(7'b001_0011, 3'b000, 5'd3, r[11:0]), a, r, 1'b0, pc_model + `PC_WD'(4));
    exec(b_word(3'b010, r[12:0]), a, a, 1'b0, pc_model + `PC_WD'(4));   // reserved funct3.
    idle_cycle(j_word(21'h00_0100));
    idle_cycle(b_word(3'b000, 13'h0010));
    end_test("plain and idle", start);
  endtask

  initial begin
    rst_n      = 1'b0;
    valid      = 1'b0;
    inst       = '0;
    rs1        = '0;
    rs2        = '0;
    lfsr_q     = 16'd89;
    pc_model   = `RESET_PC;
    mepc_model = '0;
    reset_ok   = 1'b0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    wait_reset_done(reset_ok);
    if (reset_ok) begin
      test_reset();
      test_cond();
      test_jump();
      test_trap();
      test_plain();
    end else begin
      errors++;
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/rv_inst_pkg.sv
hw/br_pkg.sv
hw/br_bus_if.sv
hw/br_decode.sv
hw/bru.sv
hw/pc_ctrl.sv
hw/bru_top.sv
dv/bru_props.sv
dv/bru_tb.sv

// ==== Makefile ====
# Verilator build and run of the branch slice testbench.
# Override any variable on the command line, e.g. make run LOG=out.log

VERILATOR ?= verilator
TOP       ?= bru_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
